// File: source/qa_pkg.sv
// Definitions shared by the host-to-device message channel

package qa_pkg;

    // ====================
    // Widths
    // ====================

    // One host cache line
    localparam int line_bits = 256;

    // One message chunk as the client sees it
    localparam int chunk_bits = 64;

    // Chunks carried by one cache line
    localparam int chunks_per_line = line_bits / chunk_bits;

    // ====================
    // Vector types
    // ====================

    typedef logic [line_bits-1:0] line_t;
    typedef logic [chunk_bits-1:0] chunk_t;

    // Host memory is addressed in whole lines
    typedef logic [31:0] line_addr_t;

    // Scoreboard slot carried with a read and returned with its response.
    // Six bits bound the scoreboard at 64 slots
    typedef logic [5:0] tag_t;

    // Payload chunk count, taken from the low bits of a message header
    typedef logic [15:0] chunk_count_t;

    // ====================
    // Memory read port
    // ====================

    // Ring data reads and status reads share one port, so the kind travels
    // with the request and comes back with the response
    typedef enum logic
    {
        kind_data   = 1'b0,
        kind_status = 1'b1
    } mem_kind_e;

    typedef struct packed
    {
        line_addr_t addr;
        mem_kind_e  kind;
        tag_t       tag;
    } mem_req_t;

    typedef struct packed
    {
        mem_kind_e kind;
        tag_t      tag;
        line_t     data;
    } mem_rsp_t;

endpackage

// File: source/qa_fifo2.sv
`timescale 1ns/10ps

module qa_fifo2
(
    input  logic           clk,
    input  logic           resetb,
    input  qa_pkg::chunk_t in_data,
    input  logic           in_valid,
    output logic           in_ready,
    output qa_pkg::chunk_t out_data,
    output logic           out_valid,
    input  logic           out_ready
);

    // Entry 0 drives the output directly and entry 1 is the overflow slot,
    // so both output signals come straight from flops
    qa_pkg::chunk_t data0;
    qa_pkg::chunk_t data1;
    logic           valid0;
    logic           valid1;
    logic           push;
    logic           pop;

    // Only a full buffer refuses data
    assign in_ready  = !valid1;
    assign out_data  = data0;
    assign out_valid = valid0;

    assign push = in_valid && in_ready;
    assign pop  = valid0 && out_ready;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            valid0 <= 1'b0;
            valid1 <= 1'b0;
        end
        else if (pop)
        begin
            // A push never happens with entry 1 full, so at most one entry stays
            valid0 <= valid1 || push;
            valid1 <= 1'b0;
        end
        else if (push)
        begin
            if (valid0)
                valid1 <= 1'b1;
            else
                valid0 <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        // Head takes the overflow entry when it drains, else the new chunk
        if (pop)
            data0 <= valid1 ? data1 : in_data;
        else if (push && !valid0)
            data0 <= in_data;

        // Entry 1 is only meaningful while valid1 is set
        if (push)
            data1 <= in_data;
    end

endmodule

// File: source/qa_scoreboard.sv
`timescale 1ns/10ps

module qa_scoreboard
#(
    parameter int sb_entries = 8
)
(
    input  logic          clk,
    input  logic          resetb,
    input  logic          alloc_en,
    output logic          alloc_ready,
    output qa_pkg::tag_t  alloc_tag,
    input  logic          fill_en,
    input  qa_pkg::tag_t  fill_tag,
    input  qa_pkg::line_t fill_data,
    output logic          head_valid,
    output qa_pkg::line_t head_data,
    input  logic          release_en
);

    localparam int idx_bits = (sb_entries > 1) ? $clog2(sb_entries) : 1;

    typedef logic [idx_bits-1:0] slot_idx_t;
    typedef logic [$clog2(sb_entries+1)-1:0] slot_count_t;

    // Line storage, one entry per slot
    qa_pkg::line_t store [sb_entries];

    // Set when a slot's response has arrived
    logic [sb_entries-1:0] filled;

    // Slots are handed out and released in the same circular order
    slot_idx_t   alloc_ptr;
    slot_idx_t   release_ptr;
    slot_count_t used;
    slot_idx_t   fill_idx;

    // Step a slot pointer, wrapping at the slot count even when it is not
    // a power of two
    function automatic slot_idx_t next_slot(slot_idx_t idx);
        if (idx == slot_idx_t'(sb_entries - 1))
            return '0;
        return idx + slot_idx_t'(1);
    endfunction

    assign fill_idx    = fill_tag[idx_bits-1:0];
    assign alloc_ready = (used != slot_count_t'(sb_entries));
    assign alloc_tag   = qa_pkg::tag_t'(alloc_ptr);

    // The head leaves only in order, whatever order the fills arrive in
    assign head_valid = filled[release_ptr];
    assign head_data  = store[release_ptr];

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            alloc_ptr   <= '0;
            release_ptr <= '0;
            used        <= '0;
            filled      <= '0;
        end
        else
        begin
            if (alloc_en)
                alloc_ptr <= next_slot(alloc_ptr);

            // A slot in flight is never the head being released, so the
            // set and the clear never hit the same bit
            if (fill_en)
                filled[fill_idx] <= 1'b1;

            if (release_en)
            begin
                filled[release_ptr] <= 1'b0;
                release_ptr <= next_slot(release_ptr);
            end

            case ({alloc_en, release_en})
                2'b10: used <= used + slot_count_t'(1);
                2'b01: used <= used - slot_count_t'(1);
                default: used <= used;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
            store[fill_idx] <= fill_data;
    end

endmodule

// File: source/qa_fifo_from_host.sv
`timescale 1ns/10ps

module qa_fifo_from_host
#(
    parameter int ring_idx_bits = 4,
    parameter int sb_entries = 8
)
(
    input  logic                     clk,
    input  logic                     resetb,
    input  qa_pkg::line_addr_t       ring_base,
    input  logic [ring_idx_bits-1:0] newest_idx,
    output qa_pkg::mem_req_t         req,
    output logic                     req_valid,
    input  logic                     req_ready,
    input  qa_pkg::mem_rsp_t         rsp,
    input  logic                     rsp_valid,
    output qa_pkg::chunk_t           chunk,
    output logic                     chunk_valid,
    input  logic                     chunk_ready,
    output logic [ring_idx_bits-1:0] oldest_idx
);

    typedef logic [ring_idx_bits-1:0] ring_idx_t;
    typedef qa_pkg::chunk_t [qa_pkg::chunks_per_line-1:0] line_chunks_t;
    typedef logic [$clog2(qa_pkg::chunks_per_line)-1:0] chunk_idx_t;

    typedef enum logic [1:0]
    {
        new_message,
        read_header,
        new_line,
        valid_chunk
    } state_e;

    // Next ring line to request
    ring_idx_t     next_req_idx;
    logic          sb_alloc_ready;
    qa_pkg::tag_t  sb_alloc_tag;
    logic          sb_fill_en;
    logic          sb_head_valid;
    qa_pkg::line_t sb_head_data;
    logic          sb_release;

    state_e               state;
    qa_pkg::chunk_count_t count;
    chunk_idx_t           chunk_in_line;
    line_chunks_t         cur_line;
    logic                 out_valid;
    logic                 out_ready;
    logic                 out_push;
    logic                 last_in_line;
    logic                 continue_line;
    logic                 need_line;

    // ====================
    // Line requests
    // ====================

    // Lines are read while the host has published more and a slot is free
    assign req_valid = (next_req_idx != newest_idx) && sb_alloc_ready;

    always_comb
    begin
        // Adding the index keeps the ring free of any alignment demand,
        // though its size must stay a power of two for the index to wrap
        req.addr = ring_base + qa_pkg::line_addr_t'(next_req_idx);
        req.kind = qa_pkg::kind_data;
        req.tag  = sb_alloc_tag;
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
            next_req_idx <= '0;
        else if (req_valid && req_ready)
            next_req_idx <= next_req_idx + ring_idx_t'(1);
    end

    // Only ring data responses belong to this reader
    assign sb_fill_en = rsp_valid && (rsp.kind == qa_pkg::kind_data);

    qa_scoreboard #(
        .sb_entries(sb_entries)
    ) scoreboard (
        .clk         (clk),
        .resetb      (resetb),
        .alloc_en    (req_valid && req_ready),
        .alloc_ready (sb_alloc_ready),
        .alloc_tag   (sb_alloc_tag),
        .fill_en     (sb_fill_en),
        .fill_tag    (rsp.tag),
        .fill_data   (rsp.data),
        .head_valid  (sb_head_valid),
        .head_data   (sb_head_data),
        .release_en  (sb_release)
    );

    // The host may reuse a ring line once it has left the scoreboard
    always_ff @(posedge clk)
    begin
        if (!resetb)
            oldest_idx <= '0;
        else if (sb_release)
            oldest_idx <= oldest_idx + ring_idx_t'(1);
    end

    // ====================
    // Lines to chunks
    // ====================

    // The chunk being offered is always the low chunk of the current line
    assign out_valid = (state == valid_chunk);
    assign out_push  = out_valid && out_ready;

    assign last_in_line = (chunk_in_line == chunk_idx_t'(qa_pkg::chunks_per_line - 1));

    // Message runs past the end of this line
    assign continue_line = out_push && last_in_line && (count != qa_pkg::chunk_count_t'(1));

    // A fresh line is wanted at a message start, while waiting for one,
    // or when the current line runs out mid-message
    assign need_line  = (state == new_message) || (state == new_line) || continue_line;
    assign sb_release = need_line && sb_head_valid;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state         <= new_message;
            count         <= '0;
            chunk_in_line <= '0;
        end
        else
        begin
            case (state)
                new_message:
                begin
                    if (sb_head_valid)
                        state <= read_header;
                end

                read_header:
                begin
                    // Header chunk is consumed here and never reaches the client
                    count         <= qa_pkg::chunk_count_t'(cur_line[0]);
                    chunk_in_line <= chunk_idx_t'(1);
                    if (qa_pkg::chunk_count_t'(cur_line[0]) == '0)
                        state <= new_message;
                    else
                        state <= valid_chunk;
                end

                new_line:
                begin
                    chunk_in_line <= '0;
                    if (sb_head_valid)
                        state <= valid_chunk;
                end

                valid_chunk:
                begin
                    if (out_push)
                    begin
                        // Rest of the line after a message end is dropped
                        if (count == qa_pkg::chunk_count_t'(1))
                            state <= new_message;
                        else if (last_in_line && !sb_head_valid)
                            state <= new_line;
                        count         <= count - qa_pkg::chunk_count_t'(1);
                        chunk_in_line <= chunk_in_line + chunk_idx_t'(1);
                    end
                end

                default: state <= new_message;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (sb_release)
            cur_line <= sb_head_data;
        else if ((state == read_header) || out_push)
            // Shift the next chunk down into the output position
            cur_line <= line_chunks_t'(cur_line >> qa_pkg::chunk_bits);
    end

    // Registered output stage keeps chunk_ready off the state machine path
    qa_fifo2 out_buf (
        .clk       (clk),
        .resetb    (resetb),
        .in_data   (cur_line[0]),
        .in_valid  (out_valid),
        .in_ready  (out_ready),
        .out_data  (chunk),
        .out_valid (chunk_valid),
        .out_ready (chunk_ready)
    );

endmodule

// File: source/qa_status_poll.sv
`timescale 1ns/10ps

module qa_status_poll
#(
    parameter int poll_interval = 32,
    parameter int ring_idx_bits = 4
)
(
    input  logic                     clk,
    input  logic                     resetb,
    input  qa_pkg::line_addr_t       status_addr,
    output qa_pkg::mem_req_t         req,
    output logic                     req_valid,
    input  logic                     req_ready,
    input  qa_pkg::mem_rsp_t         rsp,
    input  logic                     rsp_valid,
    output logic [ring_idx_bits-1:0] newest_idx
);

    typedef logic [$clog2(poll_interval+1)-1:0] timer_t;

    typedef enum logic [1:0]
    {
        wait_timer,
        issue_read,
        wait_status
    } state_e;

    state_e state;
    timer_t timer;
    logic   status_rsp;

    assign status_rsp = rsp_valid && (rsp.kind == qa_pkg::kind_status);

    // One status read at a time, from a fixed line
    assign req_valid = (state == issue_read);

    always_comb
    begin
        req.addr = status_addr;
        req.kind = qa_pkg::kind_status;
        req.tag  = '0;
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state      <= wait_timer;
            timer      <= timer_t'(poll_interval - 1);
            newest_idx <= '0;
        end
        else
        begin
            case (state)
                wait_timer:
                begin
                    if (timer == '0)
                        state <= issue_read;
                    else
                        timer <= timer - timer_t'(1);
                end

                issue_read:
                begin
                    if (req_ready)
                        state <= wait_status;
                end

                wait_status:
                begin
                    // The host publishes its newest line in the low bits
                    if (status_rsp)
                    begin
                        newest_idx <= rsp.data[ring_idx_bits-1:0];
                        timer      <= timer_t'(poll_interval - 1);
                        state      <= wait_timer;
                    end
                end

                default: state <= wait_timer;
            endcase
        end
    end

endmodule

// File: source/qa_read_arb.sv
`timescale 1ns/10ps

module qa_read_arb
(
    input  logic             clk,
    input  logic             resetb,
    input  qa_pkg::mem_req_t ring_req,
    input  logic             ring_valid,
    output logic             ring_ready,
    input  qa_pkg::mem_req_t poll_req,
    input  logic             poll_valid,
    output logic             poll_ready,
    output qa_pkg::mem_req_t mem_req,
    output logic             mem_req_valid,
    input  logic             mem_req_ready
);

    // Set when the poller wins a tie. It flips after every transfer and
    // holds the current grant while a request waits, so a stalled request
    // is never swapped for the other one
    logic prio_poll;
    logic grant_poll;

    assign grant_poll    = poll_valid && (!ring_valid || prio_poll);
    assign mem_req       = grant_poll ? poll_req : ring_req;
    assign mem_req_valid = ring_valid || poll_valid;
    assign ring_ready    = mem_req_ready && !grant_poll;
    assign poll_ready    = mem_req_ready && grant_poll;

    always_ff @(posedge clk)
    begin
        if (!resetb)
            prio_poll <= 1'b0;
        else if (mem_req_valid)
            prio_poll <= mem_req_ready ? !grant_poll : grant_poll;
    end

endmodule

// File: source/qa_top.sv
`timescale 1ns/10ps

module qa_top
#(
    parameter int ring_idx_bits = 4,
    parameter int sb_entries = 8,
    parameter int poll_interval = 32
)
(
    input  logic                     clk,
    input  logic                     resetb,
    input  qa_pkg::line_addr_t       ring_base,
    input  qa_pkg::line_addr_t       status_addr,
    output qa_pkg::mem_req_t         mem_req,
    output logic                     mem_req_valid,
    input  logic                     mem_req_ready,
    input  qa_pkg::mem_rsp_t         mem_rsp,
    input  logic                     mem_rsp_valid,
    output qa_pkg::chunk_t           chunk,
    output logic                     chunk_valid,
    input  logic                     chunk_ready,
    output logic [ring_idx_bits-1:0] oldest_idx
);

    qa_pkg::mem_req_t         ring_req;
    logic                     ring_valid;
    logic                     ring_ready;
    qa_pkg::mem_req_t         poll_req;
    logic                     poll_valid;
    logic                     poll_ready;
    logic [ring_idx_bits-1:0] newest_idx;

    // Both peers see every response and each keeps only its own kind
    qa_fifo_from_host #(
        .ring_idx_bits (ring_idx_bits),
        .sb_entries    (sb_entries)
    ) reader (
        .clk         (clk),
        .resetb      (resetb),
        .ring_base   (ring_base),
        .newest_idx  (newest_idx),
        .req         (ring_req),
        .req_valid   (ring_valid),
        .req_ready   (ring_ready),
        .rsp         (mem_rsp),
        .rsp_valid   (mem_rsp_valid),
        .chunk       (chunk),
        .chunk_valid (chunk_valid),
        .chunk_ready (chunk_ready),
        .oldest_idx  (oldest_idx)
    );

    qa_status_poll #(
        .poll_interval (poll_interval),
        .ring_idx_bits (ring_idx_bits)
    ) poller (
        .clk         (clk),
        .resetb      (resetb),
        .status_addr (status_addr),
        .req         (poll_req),
        .req_valid   (poll_valid),
        .req_ready   (poll_ready),
        .rsp         (mem_rsp),
        .rsp_valid   (mem_rsp_valid),
        .newest_idx  (newest_idx)
    );

    qa_read_arb arb (
        .clk           (clk),
        .resetb        (resetb),
        .ring_req      (ring_req),
        .ring_valid    (ring_valid),
        .ring_ready    (ring_ready),
        .poll_req      (poll_req),
        .poll_valid    (poll_valid),
        .poll_ready    (poll_ready),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready)
    );

endmodule

// File: bench/qa_host_model.sv
`timescale 1ns/10ps

module qa_host_model
#(
    parameter qa_pkg::line_addr_t ring_base = 32'h0000_1000,
    parameter qa_pkg::line_addr_t status_addr = 32'h0000_2000,
    parameter int ring_lines = 16
)
(
    input  logic             clk,
    input  qa_pkg::mem_req_t mem_req,
    input  logic             mem_req_valid,
    output logic             mem_req_ready,
    output qa_pkg::mem_rsp_t mem_rsp,
    output logic             mem_rsp_valid
);

    // Host copy of the ring and of the status line
    qa_pkg::line_t    ring [ring_lines];
    qa_pkg::line_t    status_line;
    qa_pkg::mem_req_t pending [$];
    qa_pkg::mem_req_t picked;
    logic [7:0]       lfsr;
    int               delay;
    int               pick;

    // Galois LFSR, x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] next_lfsr(logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic int random_bits(int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            val  = (val << 1) | int'(lfsr[0]);
            lfsr = next_lfsr(lfsr);
        end
        return val;
    endfunction

    function automatic qa_pkg::line_t read_line(qa_pkg::line_addr_t addr);
        qa_pkg::line_addr_t offset;
        offset = addr - ring_base;
        if (addr == status_addr)
            return status_line;
        if (offset < qa_pkg::line_addr_t'(ring_lines))
            return ring[offset];
        // Lines outside the ring and status read back as their own address
        return {8{addr}};
    endfunction

    task automatic write_line(input int idx, input qa_pkg::line_t data);
        ring[idx] = data;
    endtask

    task automatic set_status(input int newest);
        status_line = qa_pkg::line_t'(newest);
    endtask

    initial
    begin
        lfsr          = 8'd61;
        delay         = 0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        status_line   = '0;
        for (int i = 0; i < ring_lines; i++)
            ring[i] = {8{ring_base + qa_pkg::line_addr_t'(i)}};
    end

    // Everything changes on the falling edge, so the DUT sees stable inputs
    always @(negedge clk)
    begin
        mem_rsp_valid = 1'b0;
        if (pending.size() > 0)
        begin
            if (delay == 0)
            begin
                // Any pending read may go next, which reorders responses
                pick          = random_bits(2) % pending.size();
                picked        = pending[pick];
                pending.delete(pick);
                mem_rsp.kind  = picked.kind;
                mem_rsp.tag   = picked.tag;
                mem_rsp.data  = read_line(picked.addr);
                mem_rsp_valid = 1'b1;
                delay         = random_bits(3);
            end
            else
                delay = delay - 1;
        end

        // Request and ready hold until the next rising edge, so this is the transfer
        mem_req_ready = (pending.size() < 4);
        if (mem_req_valid && mem_req_ready)
            pending.push_back(mem_req);
    end

endmodule

// File: bench/qa_assertions.sv
`timescale 1ns/10ps

module qa_assertions
(
    input logic             clk,
    input logic             resetb,
    input qa_pkg::mem_req_t mem_req,
    input logic             mem_req_valid,
    input logic             mem_req_ready,
    input qa_pkg::chunk_t   chunk,
    input logic             chunk_valid,
    input logic             chunk_ready
);

    // A waiting request keeps valid and its contents
    req_held: assert property (@(posedge clk) disable iff (!resetb)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("memory request dropped or changed while waiting");

    chunk_held: assert property (@(posedge clk) disable iff (!resetb)
        chunk_valid && !chunk_ready |=> chunk_valid && $stable(chunk))
        else $error("client chunk dropped or changed while waiting");

    // The first reset edge only loads the flops
    quiet_in_reset: assert property (@(posedge clk)
        !resetb && $past(!resetb) |-> !chunk_valid)
        else $error("chunk valid during reset");

endmodule

bind qa_top qa_assertions handshake_checks
(
    .clk           (clk),
    .resetb        (resetb),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .chunk         (chunk),
    .chunk_valid   (chunk_valid),
    .chunk_ready   (chunk_ready)
);

// File: bench/qa_tb.sv
`timescale 1ns/10ps

module qa_tb;

    localparam int ring_idx_bits = 4;
    localparam int ring_size = 1 << ring_idx_bits;
    localparam int wait_limit = 3000;
    localparam qa_pkg::line_addr_t ring_base = 32'h0000_1000;
    localparam qa_pkg::line_addr_t status_addr = 32'h0000_2000;

    typedef logic [ring_idx_bits-1:0] ring_idx_t;

    logic               clk;
    logic               resetb;
    qa_pkg::mem_req_t   mem_req;
    logic               mem_req_valid;
    logic               mem_req_ready;
    qa_pkg::mem_rsp_t   mem_rsp;
    logic               mem_rsp_valid;
    qa_pkg::chunk_t     chunk;
    logic               chunk_valid;
    logic               chunk_ready;
    ring_idx_t          oldest_idx;

    // Host write pointer and the payload chunks the client still expects
    ring_idx_t          wr_idx;
    qa_pkg::chunk_t     expected [$];
    logic [7:0]         lfsr;
    int                 errors;
    int                 checks;
    int                 tests;
    int                 test_errors;

    qa_top #(
        .ring_idx_bits (ring_idx_bits),
        .sb_entries    (8),
        .poll_interval (32)
    ) dut (
        .clk           (clk),
        .resetb        (resetb),
        .ring_base     (ring_base),
        .status_addr   (status_addr),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp       (mem_rsp),
        .mem_rsp_valid (mem_rsp_valid),
        .chunk         (chunk),
        .chunk_valid   (chunk_valid),
        .chunk_ready   (chunk_ready),
        .oldest_idx    (oldest_idx)
    );

    qa_host_model #(
        .ring_base   (ring_base),
        .status_addr (status_addr),
        .ring_lines  (ring_size)
    ) host (
        .clk           (clk),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp       (mem_rsp),
        .mem_rsp_valid (mem_rsp_valid)
    );

    always #5 clk = ~clk;

    // ====================
    // Helpers
    // ====================

    function automatic logic [7:0] step_lfsr(logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
    endfunction

    // Payload marks the message and the chunk position
    function automatic qa_pkg::chunk_t payload(int msg, int j);
        return {16'hc0de, 16'(msg), 32'(j)};
    endfunction

    task automatic compare_chunk(input string name, input qa_pkg::chunk_t exp,
                                 input qa_pkg::chunk_t act);
        checks++;
        if (exp !== act)
        begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_idx(input string name, input ring_idx_t exp, input ring_idx_t act);
        checks++;
        if (exp !== act)
        begin
            $display("Mismatch in %s: expected oldest_idx %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // Header chunk holds the count, then the payload, packed into fresh lines
    task automatic write_message(input string name, input int msg, input int count);
        qa_pkg::line_t line;
        qa_pkg::chunk_t value;
        int lines;
        int t;
        int j;
        lines = (count + qa_pkg::chunks_per_line) / qa_pkg::chunks_per_line;
        t = 0;
        // One ring line always stays empty so full and empty differ
        while ((int'(ring_idx_t'(oldest_idx - wr_idx - ring_idx_t'(1))) < lines)
               && (t < wait_limit))
        begin
            @(negedge clk);
            t++;
        end
        if (t >= wait_limit)
        begin
            $display("%s: timed out waiting for free ring lines", name);
            errors++;
        end
        for (int l = 0; l < lines; l++)
        begin
            for (int k = 0; k < qa_pkg::chunks_per_line; k++)
            begin
                j = l * qa_pkg::chunks_per_line + k;
                if (j == 0)
                    value = qa_pkg::chunk_t'(count);
                else if (j <= count)
                begin
                    value = payload(msg, j);
                    expected.push_back(value);
                end
                else
                    value = 64'hf111_f111_f111_f111;
                line[k*qa_pkg::chunk_bits +: qa_pkg::chunk_bits] = value;
            end
            host.write_line(int'(wr_idx), line);
            wr_idx = wr_idx + ring_idx_t'(1);
        end
        host.set_status(int'(wr_idx));
    endtask

    // Takes n chunks, with chunk_ready from the LFSR when throttled
    task automatic receive_chunks(input string name, input int n, input bit throttle);
        int t;
        bit got;
        for (int i = 0; i < n; i++)
        begin
            t = 0;
            got = 0;
            while (!got && (t < wait_limit))
            begin
                @(negedge clk);
                t++;
                if (throttle)
                begin
                    chunk_ready = lfsr[0];
                    lfsr = step_lfsr(lfsr);
                end
                else
                    chunk_ready = 1'b1;
                if (chunk_valid && chunk_ready)
                begin
                    got = 1;
                    compare_chunk(name, expected.pop_front(), chunk);
                end
            end
            if (!got)
            begin
                $display("%s: timed out waiting for chunk %0d of %0d", name, i + 1, n);
                errors++;
                i = n;
            end
        end
        @(negedge clk);
        chunk_ready = 1'b0;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("%s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // ====================
    // Directed tests
    // ====================

    task automatic single_line_message();
        write_message("single_line", 1, 3);
        receive_chunks("single_line", 3, 0);
        finish_test("single_line");
    endtask

    task automatic spanning_message();
        write_message("spanning", 2, 9);
        receive_chunks("spanning", 9, 0);
        finish_test("spanning");
    endtask

    task automatic throttled_burst();
        int counts [5];
        int total;
        counts = '{2, 5, 3, 7, 1};
        total = 0;
        for (int m = 0; m < 5; m++)
        begin
            write_message("throttled", 10 + m, counts[m]);
            total += counts[m];
        end
        receive_chunks("throttled", total, 1);
        finish_test("throttled");
    endtask

    task automatic oldest_after_drain();
        ring_idx_t start;
        // Every earlier line has drained, so the message starts at the host write pointer
        start = wr_idx;
        // Seven chunks with the header take two lines
        write_message("oldest_idx", 20, 6);
        receive_chunks("oldest_idx", 6, 0);
        compare_idx("oldest_idx", start + ring_idx_t'(2), oldest_idx);
        finish_test("oldest_idx");
    endtask

    task automatic ring_wrap();
        for (int m = 0; m < 20; m++)
        begin
            write_message("wrap", 100 + m, 3);
            receive_chunks("wrap", 3, 0);
            compare_idx("wrap", wr_idx, oldest_idx);
        end
        finish_test("wrap");
    endtask

    initial
    begin
        clk = 1'b0;
        resetb = 1'b0;
        chunk_ready = 1'b0;
        wr_idx = '0;
        lfsr = 8'd61;
        errors = 0;
        checks = 0;
        tests = 0;
        test_errors = 0;
        repeat (16) @(negedge clk);
        resetb = 1'b1;

        single_line_message();
        spanning_message();
        throttled_burst();
        oldest_after_drain();
        ring_wrap();

        if (expected.size() != 0)
        begin
            $display("%0d expected chunks never arrived", expected.size());
            errors++;
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: compile.f
source/qa_pkg.sv
source/qa_fifo2.sv
source/qa_scoreboard.sv
source/qa_fifo_from_host.sv
source/qa_status_poll.sv
source/qa_read_arb.sv
source/qa_top.sv
bench/qa_host_model.sv
bench/qa_assertions.sv
bench/qa_tb.sv

// File: run.sh
#!/bin/bash
# Build the testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module qa_tb -o qa_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/qa_sim > sim.log 2>&1
cat sim.log

grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
